/* src/neighbor_settings.svh */
`ifndef NEIGHBOR_SETTINGS_SVH
`define NEIGHBOR_SETTINGS_SVH

// one neighbor id, two of them per bank word.
`define NEIGHBOR_ID_W 16
`define NEIGHBOR_DATA_W (2 * `NEIGHBOR_ID_W)

`define BANK_ROWS 64
`define ROW_ADDR_W $clog2(`BANK_ROWS)

`define MAX_DEGREE 31
`define DEGREE_W $clog2(`MAX_DEGREE + 1)

`define NUM_EDGE_PE 4
`define PE_TAG_W $clog2(`NUM_EDGE_PE)

// row in the upper bits, degree in the lower.
`define BANK_ADDR_W (`ROW_ADDR_W + `DEGREE_W)

`define REQ_DEPTH 4

`endif

/* src/graph_req_pkg.sv */
`include "neighbor_settings.svh"

package graph_req_pkg;

    typedef struct packed {
        logic [`ROW_ADDR_W-1:0] row;    // first bank row of the list.
        logic [`DEGREE_W-1:0]   degree; // neighbor count.
    } bank_field_t;

    // requester hands over a flat word, controller reads the fields.
    typedef union packed {
        logic [`BANK_ADDR_W-1:0] raw;
        bank_field_t             field;
    } bank_addr_t;

    typedef struct packed {
        logic                 valid;
        bank_addr_t           bank_addr;
        logic [`PE_TAG_W-1:0] pe_tag;
    } fetch_req_t;

    // beats per request, two neighbors per beat and never fewer than one.
    function automatic logic [`DEGREE_W-1:0] beat_count(
        input logic [`DEGREE_W-1:0] degree
    );
        logic [`DEGREE_W:0] rounded;
        logic               is_zero;
        rounded = {1'b0, degree} + {{`DEGREE_W{1'b0}}, 1'b1};
        is_zero = (degree == '0);
        return rounded[`DEGREE_W:1] | {{(`DEGREE_W-1){1'b0}}, is_zero};
    endfunction

endpackage

/* src/bank_stream_pkg.sv */
`include "neighbor_settings.svh"

package bank_stream_pkg;

    typedef struct packed {
        logic                   cen; // read enable.
        logic [`ROW_ADDR_W-1:0] a;
    } sram_port_t;

    // one beat per bank row toward the edge PEs.
    typedef struct packed {
        logic                        valid;
        logic                        sos;    // first beat of a list.
        logic                        eos;    // last beat of a list.
        logic [`PE_TAG_W-1:0]        pe_tag;
        logic [`DEGREE_W-1:0]        degree;
        logic [`NEIGHBOR_DATA_W-1:0] data;
    } edge_beat_t;

endpackage

/* src/neighbor_req_queue.sv */
`timescale 1ns/1ns
`include "neighbor_settings.svh"

module neighbor_req_queue #(
    parameter int DEPTH = `REQ_DEPTH
) (
    input  logic                     clk,
    input  logic                     reset,
    input  graph_req_pkg::fetch_req_t fetch_req,
    input  logic                     pop,
    output graph_req_pkg::fetch_req_t head,
    output logic                     req_full
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);
    localparam logic [PTR_W-1:0] LAST_SLOT = PTR_W'(DEPTH - 1);
    localparam logic [PTR_W-1:0] PTR_STEP = PTR_W'(1);
    localparam logic [CNT_W-1:0] CNT_STEP = CNT_W'(1);

    graph_req_pkg::fetch_req_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             empty;
    logic             push;
    logic             take;

    assign empty    = (count == '0);
    assign req_full = (count == CNT_W'(DEPTH));
    assign take     = pop && !empty;
    // a full queue still accepts when the head leaves this cycle.
    assign push     = fetch_req.valid && (!req_full || take);

    always_ff @(posedge clk) begin
        if (push) begin
            mem[wr_ptr] <= fetch_req;
        end
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (push) begin
                wr_ptr <= (wr_ptr == LAST_SLOT) ? '0 : wr_ptr + PTR_STEP;
            end
            if (take) begin
                rd_ptr <= (rd_ptr == LAST_SLOT) ? '0 : rd_ptr + PTR_STEP;
            end
            case ({push, take})
                2'b10:   count <= count + CNT_STEP;
                2'b01:   count <= count - CNT_STEP;
                default: count <= count;
            endcase
        end
    end

    // oldest entry, flagged valid while anything is held.
    always_comb begin
        head       = mem[rd_ptr];
        head.valid = !empty;
    end

endmodule

/* src/neighbor_sram.sv */
`timescale 1ns/1ns
`include "neighbor_settings.svh"

module neighbor_sram (
    input  logic                        clk,
    input  bank_stream_pkg::sram_port_t sram_port,
    input  logic                        load_en,
    input  logic [`ROW_ADDR_W-1:0]      load_addr,
    input  logic [`NEIGHBOR_DATA_W-1:0] load_data,
    output logic [`NEIGHBOR_DATA_W-1:0] rdata
);

    logic [`NEIGHBOR_DATA_W-1:0] mem [`BANK_ROWS];

    // single port, a load wins over a read in the same cycle.
    always_ff @(posedge clk) begin
        if (load_en) begin
            mem[load_addr] <= load_data;
        end else if (sram_port.cen) begin
            rdata <= mem[sram_port.a]; // held while cen is low.
        end
    end

endmodule

/* src/neighbor_bank_cntl.sv */
`timescale 1ns/1ns
`include "neighbor_settings.svh"

module neighbor_bank_cntl (
    input  logic                        clk,
    input  logic                        reset,
    input  graph_req_pkg::fetch_req_t   head,
    input  logic [`NEIGHBOR_DATA_W-1:0] rdata,
    output logic                        pop,
    output bank_stream_pkg::sram_port_t sram_port,
    output bank_stream_pkg::edge_beat_t beat,
    output logic                        busy
);

    localparam logic [`DEGREE_W-1:0]   ONE_BEAT = {{(`DEGREE_W-1){1'b0}}, 1'b1};
    localparam logic [`ROW_ADDR_W-1:0] ROW_STEP = {{(`ROW_ADDR_W-1){1'b0}}, 1'b1};

    typedef enum logic {
        st_idle,
        st_stream
    } state_t;

    state_t                      state, nx_state;
    bank_stream_pkg::sram_port_t nx_port;
    logic [`ROW_ADDR_W-1:0]      row_q, nx_row;
    logic [`DEGREE_W-1:0]        left_q, nx_left;
    logic [`PE_TAG_W-1:0]        tag_q, nx_tag;
    logic [`DEGREE_W-1:0]        degree_q, nx_degree;
    logic [`DEGREE_W-1:0]        head_beats;
    logic                        rd_sos, nx_sos;
    logic                        rd_eos, nx_eos;

    // framing for the beat whose data is in the bank output register.
    logic                        beat_valid;
    logic                        beat_sos;
    logic                        beat_eos;
    logic [`PE_TAG_W-1:0]        beat_tag;
    logic [`DEGREE_W-1:0]        beat_degree;

    assign head_beats = graph_req_pkg::beat_count(head.bank_addr.field.degree);

    always_comb begin
        nx_state  = state;
        nx_row    = row_q;
        nx_left   = left_q;
        nx_tag    = tag_q;
        nx_degree = degree_q;
        nx_port   = '0;
        nx_sos    = 1'b0;
        nx_eos    = 1'b0;
        pop       = 1'b0;
        case (state)
            st_idle: begin
                if (head.valid) begin
                    pop         = 1'b1;
                    nx_port.cen = 1'b1;
                    nx_port.a   = head.bank_addr.field.row;
                    nx_sos      = 1'b1;
                    nx_eos      = (head_beats == ONE_BEAT);
                    nx_row      = head.bank_addr.field.row + ROW_STEP;
                    nx_left     = head_beats - ONE_BEAT;
                    nx_tag      = head.pe_tag;
                    nx_degree   = head.bank_addr.field.degree;
                    if (head_beats != ONE_BEAT) begin
                        nx_state = st_stream;
                    end
                end
            end
            st_stream: begin
                nx_port.cen = 1'b1;
                nx_port.a   = row_q;
                nx_eos      = (left_q == ONE_BEAT);
                nx_row      = row_q + ROW_STEP;
                nx_left     = left_q - ONE_BEAT;
                if (left_q == ONE_BEAT) begin
                    nx_state = st_idle; // next head can go out right away.
                end
            end
            default: nx_state = st_idle;
        endcase
    end

    always_ff @(posedge clk) begin
        if (reset) begin
            state      <= st_idle;
            sram_port  <= '0;
            rd_sos     <= 1'b0;
            rd_eos     <= 1'b0;
            beat_valid <= 1'b0;
            beat_sos   <= 1'b0;
            beat_eos   <= 1'b0;
        end else begin
            state      <= nx_state;
            sram_port  <= nx_port;
            rd_sos     <= nx_sos;
            rd_eos     <= nx_eos;
            beat_valid <= sram_port.cen;
            beat_sos   <= rd_sos;
            beat_eos   <= rd_eos;
        end
    end

    always_ff @(posedge clk) begin
        row_q       <= nx_row;
        left_q      <= nx_left;
        tag_q       <= nx_tag;
        degree_q    <= nx_degree;
        beat_tag    <= tag_q;
        beat_degree <= degree_q;
    end

    always_comb begin
        beat.valid  = beat_valid;
        beat.sos    = beat_sos;
        beat.eos    = beat_eos;
        beat.pe_tag = beat_tag;
        beat.degree = beat_degree;
        beat.data   = rdata; // bank output is already registered.
    end

    // low again once only the eos read is left in flight.
    assign busy = pop || (state == st_stream) || sram_port.cen;

endmodule

/* src/neighbor_fetch_top.sv */
`timescale 1ns/1ns
`include "neighbor_settings.svh"

module neighbor_fetch_top (
    input  logic                        clk,
    input  logic                        reset,
    input  graph_req_pkg::fetch_req_t   fetch_req,
    output logic                        req_full,
    input  logic                        load_en,
    input  logic [`ROW_ADDR_W-1:0]      load_addr,
    input  logic [`NEIGHBOR_DATA_W-1:0] load_data,
    output bank_stream_pkg::edge_beat_t beat,
    output logic                        busy
);

    graph_req_pkg::fetch_req_t   head;
    logic                        pop;
    bank_stream_pkg::sram_port_t sram_port;
    logic [`NEIGHBOR_DATA_W-1:0] rdata;

    neighbor_req_queue #(
        .DEPTH(`REQ_DEPTH)
    ) neighbor_req_queue_i (
        .clk      (clk),
        .reset    (reset),
        .fetch_req(fetch_req),
        .pop      (pop),
        .head     (head),
        .req_full (req_full)
    );

    neighbor_sram neighbor_sram_i (
        .clk      (clk),
        .sram_port(sram_port),
        .load_en  (load_en),
        .load_addr(load_addr),
        .load_data(load_data),
        .rdata    (rdata)
    );

    neighbor_bank_cntl neighbor_bank_cntl_i (
        .clk      (clk),
        .reset    (reset),
        .head     (head),
        .rdata    (rdata),
        .pop      (pop),
        .sram_port(sram_port),
        .beat     (beat),
        .busy     (busy)
    );

endmodule

/* sim/neighbor_fetch_tb.sv */
`timescale 1ns/1ns
`include "neighbor_settings.svh"

module neighbor_fetch_tb;

    localparam int WAIT_LIMIT = 200;

    typedef struct packed {
        bank_stream_pkg::edge_beat_t beat;
        logic [15:0]                 req_id;
        logic [7:0]                  index;
    } expected_beat_t;

    logic                        clk;
    logic                        reset;
    graph_req_pkg::fetch_req_t   fetch_req;
    logic                        req_full;
    logic                        load_en;
    logic [`ROW_ADDR_W-1:0]      load_addr;
    logic [`NEIGHBOR_DATA_W-1:0] load_data;
    bank_stream_pkg::edge_beat_t beat;
    logic                        busy;

    logic [`NEIGHBOR_DATA_W-1:0] bank_model [`BANK_ROWS];
    expected_beat_t              exp_q [$];
    int                          model_fifo [$];      // beat counts of queued requests.
    int                          model_left = 0;      // stream cycles left after the pop.
    logic                        model_tail = 1'b0;   // eos read still on the bank port.
    integer                      seed = 32'haae0c3e8;
    int                          errors = 0;
    int                          timeouts = 0;
    int                          checked = 0;
    int                          req_count = 0;
    int                          last_beats = 0;
    logic                        started = 1'b0;
    logic                        aborted = 1'b0;
    logic                        abut_check = 1'b0;
    logic                        seen_first = 1'b0;

    neighbor_fetch_top neighbor_fetch_top_i (
        .clk      (clk),
        .reset    (reset),
        .fetch_req(fetch_req),
        .req_full (req_full),
        .load_en  (load_en),
        .load_addr(load_addr),
        .load_data(load_data),
        .beat     (beat),
        .busy     (busy)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // two neighbors per beat, at least one beat.
    function automatic int stream_beats(input int degree);
        if (degree == 0) begin
            return 1;
        end
        return (degree + 1) / 2;
    endfunction

    // controller takes the head when idle and the queue holds one.
    function automatic logic model_take();
        return (model_left == 0) && (model_fifo.size() != 0);
    endfunction

    function automatic logic model_full();
        return model_fifo.size() == `REQ_DEPTH;
    endfunction

    function automatic logic [`NEIGHBOR_DATA_W-1:0] fill_word(
        input logic [`ROW_ADDR_W-1:0] row
    );
        return {4'hc, row, 6'h15, 4'h3, ~row, 6'h2a};
    endfunction

    always @(posedge clk) begin : queue_model
        logic take_now;
        logic push_now;
        if (reset) begin
            model_fifo.delete();
            model_left = 0;
            model_tail = 1'b0;
        end else begin
            take_now   = model_take();
            push_now   = fetch_req.valid && (!model_full() || take_now);
            model_tail = (model_left == 1) || (take_now && model_fifo[0] == 1);
            if (take_now) begin
                model_left = model_fifo.pop_front() - 1;
            end else if (model_left != 0) begin
                model_left--;
            end
            if (push_now) begin
                model_fifo.push_back(stream_beats(fetch_req.bank_addr.raw[`DEGREE_W-1:0]));
            end
        end
    end

    task automatic load_row(input logic [`ROW_ADDR_W-1:0] row,
                            input logic [`NEIGHBOR_DATA_W-1:0] data);
        @(posedge clk);
        #1;
        fetch_req       = '0;
        load_en         = 1'b1;
        load_addr       = row;
        load_data       = data;
        bank_model[row] = data;
    endtask

    task automatic push_expected(input logic [`ROW_ADDR_W-1:0] row,
                                 input logic [`DEGREE_W-1:0] degree,
                                 input logic [`PE_TAG_W-1:0] tag);
        expected_beat_t         e;
        int                     n;
        logic [`ROW_ADDR_W-1:0] r;
        n = stream_beats(degree);
        for (int k = 0; k < n; k++) begin
            r             = row + k[`ROW_ADDR_W-1:0]; // wraps at the top of the bank.
            e.beat.valid  = 1'b1;
            e.beat.sos    = (k == 0);
            e.beat.eos    = (k == n - 1);
            e.beat.pe_tag = tag;
            e.beat.degree = degree;
            e.beat.data   = bank_model[r];
            e.req_id      = req_count[15:0];
            e.index       = k[7:0];
            exp_q.push_back(e);
        end
    endtask

    task automatic issue_request(input logic [`ROW_ADDR_W-1:0] row,
                                 input logic [`DEGREE_W-1:0] degree,
                                 input logic [`PE_TAG_W-1:0] tag,
                                 input logic wait_room);
        int   waited;
        logic accepted;
        waited = 0;
        @(posedge clk);
        #1;
        load_en   = 1'b0;
        fetch_req = '0;
        while (wait_room && model_full() && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (wait_room && model_full()) begin
            $display("timeout: queue stayed full before request %0d", req_count);
            timeouts++;
            aborted = 1'b1;
        end else begin
            started                 = 1'b1;
            accepted                = !model_full() || model_take(); // dropped when full.
            fetch_req.valid         = 1'b1;
            fetch_req.bank_addr.raw = {row, degree};
            fetch_req.pe_tag        = tag;
            if (accepted) begin
                push_expected(row, degree, tag);
            end
            last_beats = accepted ? stream_beats(degree) : 0;
            req_count++;
        end
    endtask

    task automatic check_count(input int beats);
        assert (beats == last_beats) else begin
            errors++;
            $display("** Error at %0t: request %0d listed with %0d beats, expected %0d",
                     $time, req_count - 1, beats, last_beats);
        end
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        @(posedge clk);
        #1;
        fetch_req = '0;
        load_en   = 1'b0;
        while ((exp_q.size() != 0 || busy) && waited < WAIT_LIMIT) begin
            @(posedge clk);
            #1;
            waited++;
        end
        if (exp_q.size() != 0) begin
            $display("timeout: beat %0d of request %0d never arrived",
                     exp_q[0].index, exp_q[0].req_id);
            timeouts++;
            aborted = 1'b1;
        end else if (busy) begin
            $display("timeout: busy stayed high with no beats outstanding");
            timeouts++;
            aborted = 1'b1;
        end
        repeat (4) @(posedge clk); // room for any stray beats.
        abut_check = 1'b0;
    endtask

    task automatic issue_random(input int count);
        logic [`ROW_ADDR_W-1:0] row;
        logic [`DEGREE_W-1:0]   degree;
        logic [`PE_TAG_W-1:0]   tag;
        abut_check = 1'b1;
        seen_first = 1'b0;
        for (int i = 0; i < count && !aborted; i++) begin
            row    = $random(seed);
            degree = $random(seed);
            tag    = $random(seed);
            issue_request(row, degree, tag, 1'b1);
        end
    endtask

    task automatic skip_line(input int fd);
        int ch;
        ch = $fgetc(fd);
        while (ch != 8'h0a && ch != -1) begin
            ch = $fgetc(fd);
        end
    endtask

    always @(negedge clk) begin : beat_monitor
        expected_beat_t e;
        logic           busy_exp;
        busy_exp = model_take() || (model_left != 0) || model_tail;
        if (!reset) begin
            if (!started) begin
                assert (!beat.valid && !busy && !req_full) else begin
                    errors++;
                    $display("** Error at %0t: idle outputs valid %b busy %b full %b",
                             $time, beat.valid, busy, req_full);
                end
            end
            assert (req_full === model_full()) else begin
                errors++;
                $display("** Error at %0t: req_full %b, expected %b",
                         $time, req_full, model_full());
            end
            assert (busy === busy_exp) else begin
                errors++;
                $display("** Error at %0t: busy %b, expected %b", $time, busy, busy_exp);
            end
            if (abut_check && seen_first && exp_q.size() != 0) begin
                assert (beat.valid) else begin
                    errors++;
                    $display("** Error at %0t: gap before beat %0d of request %0d",
                             $time, exp_q[0].index, exp_q[0].req_id);
                end
            end
            if (beat.valid) begin
                seen_first = abut_check;
                assert (exp_q.size() != 0) else begin
                    errors++;
                    $display("** Error at %0t: beat with data %h and none expected",
                             $time, beat.data);
                end
                if (exp_q.size() != 0) begin
                    e = exp_q.pop_front();
                    checked++;
                    assert (beat === e.beat) else begin
                        errors++;
                        $display("** Error at %0t: request %0d beat %0d got %b%b tag %0d deg %0d %h",
                                 $time, e.req_id, e.index, beat.sos, beat.eos, beat.pe_tag,
                                 beat.degree, beat.data);
                        $display("    expected %b%b tag %0d deg %0d %h", e.beat.sos, e.beat.eos,
                                 e.beat.pe_tag, e.beat.degree, e.beat.data);
                    end
                end
            end
        end
    end

    initial begin : stimulus
        int          fd;
        int          code;
        int          count;
        logic [7:0]  kind;
        logic [31:0] f1;
        logic [31:0] f2;
        logic [31:0] f3;
        logic        done;
        fetch_req = '0;
        load_en   = 1'b0;
        load_addr = '0;
        load_data = '0;
        reset     = 1'b1;
        repeat (8) @(posedge clk);
        #1;
        reset = 1'b0;
        repeat (3) @(posedge clk);
        for (int r = 0; r < `BANK_ROWS; r++) begin
            load_row(r[`ROW_ADDR_W-1:0], fill_word(r[`ROW_ADDR_W-1:0]));
        end
        fd = $fopen("sim/neighbor_vectors.txt", "r");
        if (fd == 0) begin
            $display("could not open sim/neighbor_vectors.txt");
            errors++;
        end else begin
            done = 1'b0;
            while (!done && !aborted) begin
                code = $fscanf(fd, " %c", kind);
                if (code != 1) begin
                    done = 1'b1;
                end else begin
                    case (kind)
                        "#": skip_line(fd);
                        "L": begin
                            code = $fscanf(fd, "%h %h", f1, f2);
                            load_row(f1[`ROW_ADDR_W-1:0], f2);
                        end
                        "R": begin
                            code = $fscanf(fd, "%h %h %h", f1, f2, f3);
                            issue_request(f1[`ROW_ADDR_W-1:0], f2[`DEGREE_W-1:0],
                                          f3[`PE_TAG_W-1:0], 1'b0);
                        end
                        "E": begin
                            code = $fscanf(fd, "%d", count);
                            check_count(count);
                        end
                        "W": wait_drain();
                        "X": begin
                            code = $fscanf(fd, "%d", count);
                            issue_random(count);
                        end
                        default: begin
                            $display("vector file holds an unknown line kind %c", kind);
                            errors++;
                            done = 1'b1;
                        end
                    endcase
                end
            end
            $fclose(fd);
        end
        if (!aborted) begin
            wait_drain();
        end
        $display("value errors: %0d, timeouts: %0d, beats checked: %0d",
                 errors, timeouts, checked);
        if (errors == 0 && timeouts == 0) begin
            $display("all tests passed");
        end else begin
            $display("tests failed");
        end
        $finish;
    end

endmodule

/* compile.f */
+incdir+src
src/graph_req_pkg.sv
src/bank_stream_pkg.sv
src/neighbor_req_queue.sv
src/neighbor_sram.sv
src/neighbor_bank_cntl.sv
src/neighbor_fetch_top.sv
sim/neighbor_fetch_tb.sv

/* sim/neighbor_vectors.txt */
# L row data | R row degree tag | E beats | W drain | X random requests
# row, data, degree and tag in hex; beats and random counts in decimal
L 08 00110010
L 09 00130012
L 0a 00150014
L 0b 00170016
L 14 01000001
L 15 02000002
L 16 03000003
W
# degree 7 gives four framed beats
R 08 07 1
E 4
W
# degrees 0, 1 and 2 give one beat each
R 14 00 2
E 1
R 15 01 3
E 1
R 16 02 0
E 1
W
# long stream, then five more strobes and the last one is dropped
R 20 1f 0
E 16
R 30 05 1
E 3
R 31 03 2
E 2
R 32 08 3
E 4
R 33 0a 0
E 5
R 34 06 1
E 0
W
X 14
W
